//--- rtl/decode_consts.svh
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

`define XLEN 64

// opcode field in instruction bits 6:2
`define OPC_LOAD    5'b00000
`define OPC_STORE   5'b01000
`define OPC_OPIMM   5'b00100
`define OPC_OPIMM32 5'b00110
`define OPC_OP      5'b01100
`define OPC_OP32    5'b01110
`define OPC_LUI     5'b01101
`define OPC_AUIPC   5'b00101
`define OPC_JAL     5'b11011
`define OPC_JALR    5'b11001
`define OPC_BRANCH  5'b11000
`define OPC_SYSTEM  5'b11100

// immediate formats
`define EXT_I 3'b000
`define EXT_J 3'b001
`define EXT_S 3'b010
`define EXT_B 3'b011
`define EXT_U 3'b101

// branch kinds with LT/GE shared by the unsigned compares
`define BR_NONE 3'b000
`define BR_JAL  3'b001
`define BR_JALR 3'b010
`define BR_EQ   3'b100
`define BR_NE   3'b101
`define BR_LT   3'b110
`define BR_GE   3'b111

`define INSTR_ECALL  32'h0000_0073
`define INSTR_EBREAK 32'h0010_0073
`define INSTR_MRET   32'h3020_0073

`endif

//--- rtl/decode_pkg.sv
`include "decode_consts.svh"

package decode_pkg;

    // raw instruction word
    typedef logic [31:0] instrWord;

    // program counter
    typedef logic [`XLEN-1:0] xlenWord;

    // sign-extended immediate
    typedef logic [31:0] immWord;

    // register file index
    typedef logic [4:0] regIdx;

    // immediate format as an EXT_* code
    typedef logic [2:0] extFormat;

    // ALU op is {funct7[5], funct3} for arithmetic
    typedef logic [3:0] aluCode;

    // see BR_* codes
    typedef logic [2:0] branchKind;

    // load/store size and sign from funct3
    typedef logic [2:0] memOpCode;

    // CSR address
    typedef logic [11:0] csrIdx;

    // B operand select 0 rs2, 1 const 4, 2 imm, 3 csr
    typedef logic [1:0] aluBSel;

endpackage

//--- rtl/opDecoder.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module opDecoder (
    input  logic [6:0]            opcode,
    input  logic [2:0]            funct3,
    input  logic [6:0]            funct7,
    output decode_pkg::extFormat  extFmt,
    output logic                  aluASrc,
    output decode_pkg::aluBSel    aluBSrc,
    output decode_pkg::aluCode    aluCtrl,
    output logic                  isMul,
    output logic                  isDiv,
    output decode_pkg::branchKind branch,
    output logic                  memRd,
    output logic                  memWr,
    output logic                  regWr,
    output logic                  csrOp,
    output logic                  formatError
);
    import decode_pkg::*;

    localparam aluCode aluAdd   = 4'b0000;
    localparam aluCode aluSlt   = 4'b0010;
    localparam aluCode aluSltu  = 4'b0011;
    localparam aluCode aluPassB = 4'b1111; // result is operand B

    logic mExt;    // mul/div funct7 on a register op
    logic opError; // bad funct3/funct7 for this opcode

    always_comb begin
        extFmt  = `EXT_I;
        aluASrc = 1'b0;
        aluBSrc = 2'd0;
        aluCtrl = aluAdd;
        branch  = `BR_NONE;
        memRd   = 1'b0;
        memWr   = 1'b0;
        regWr   = 1'b1;
        csrOp   = 1'b0;
        opError = 1'b0;
        case (opcode[6:2])
            `OPC_LUI: begin
                extFmt  = `EXT_U;
                aluBSrc = 2'd2;
                aluCtrl = aluPassB;
            end
            `OPC_AUIPC: begin
                extFmt  = `EXT_U;
                aluASrc = 1'b1; // pc + imm
                aluBSrc = 2'd2;
            end
            `OPC_JAL: begin
                extFmt  = `EXT_J;
                aluASrc = 1'b1; // link value pc + 4
                aluBSrc = 2'd1;
                branch  = `BR_JAL;
            end
            `OPC_JALR: begin
                aluASrc = 1'b1;
                aluBSrc = 2'd1;
                branch  = `BR_JALR;
                opError = funct3 != 3'b000;
            end
            `OPC_BRANCH: begin
                extFmt  = `EXT_B;
                regWr   = 1'b0;
                aluCtrl = funct3[1] ? aluSltu : aluSlt;
                case (funct3)
                    3'b000:         branch = `BR_EQ;
                    3'b001:         branch = `BR_NE;
                    3'b100, 3'b110: branch = `BR_LT;
                    3'b101, 3'b111: branch = `BR_GE;
                    default:        opError = 1'b1;
                endcase
            end
            `OPC_LOAD: begin
                aluBSrc = 2'd2;
                memRd   = 1'b1;
                opError = funct3 == 3'b111; // no ldu
            end
            `OPC_STORE: begin
                extFmt  = `EXT_S;
                aluBSrc = 2'd2;
                memWr   = 1'b1;
                regWr   = 1'b0;
                opError = funct3[2];
            end
            `OPC_OPIMM: begin
                aluBSrc = 2'd2;
                aluCtrl = {funct7[5] && funct3 == 3'b101, funct3};
                // funct7[0] is the top bit of the 6-bit shamt
                opError = (funct3 == 3'b001 && funct7[6:1] != 6'b000000) ||
                          (funct3 == 3'b101 && !(funct7[6:1] inside {6'b000000, 6'b010000}));
            end
            `OPC_OPIMM32: begin
                aluBSrc = 2'd2;
                aluCtrl = {funct7[5] && funct3 == 3'b101, funct3};
                case (funct3)
                    3'b000:  opError = 1'b0;
                    3'b001:  opError = funct7 != 7'b0000000;
                    3'b101:  opError = !(funct7 inside {7'b0000000, 7'b0100000});
                    default: opError = 1'b1;
                endcase
            end
            `OPC_OP: begin
                aluCtrl = {funct7[5], funct3};
                case (funct7)
                    7'b0000000, 7'b0000001: opError = 1'b0;
                    7'b0100000: opError = !(funct3 inside {3'b000, 3'b101}); // sub, sra
                    default:    opError = 1'b1;
                endcase
            end
            `OPC_OP32: begin
                aluCtrl = {funct7[5], funct3};
                case (funct7)
                    7'b0000000: opError = !(funct3 inside {3'b000, 3'b001, 3'b101});
                    7'b0100000: opError = !(funct3 inside {3'b000, 3'b101});
                    7'b0000001: opError = funct3 inside {3'b001, 3'b010, 3'b011}; // mulw only
                    default:    opError = 1'b1;
                endcase
            end
            `OPC_SYSTEM: begin
                aluBSrc = 2'd3;
                aluCtrl = aluPassB;
                csrOp   = funct3 != 3'b000; // funct3 0 is ecall/ebreak/mret
                regWr   = funct3 != 3'b000;
                opError = funct3 == 3'b100;
            end
            default: begin
                regWr   = 1'b0;
                opError = 1'b1;
            end
        endcase
    end

    assign mExt = (opcode[6:2] == `OPC_OP || opcode[6:2] == `OPC_OP32) &&
                  funct7 == 7'b0000001;
    assign isMul = mExt && !funct3[2];
    assign isDiv = mExt && funct3[2];

    assign formatError = opError || opcode[1:0] != 2'b11; // 16-bit encodings not supported

endmodule

//--- rtl/immGen.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module immGen (
    input  logic [31:7]          instrBits,
    input  decode_pkg::extFormat extFmt,
    output decode_pkg::immWord   imm
);
    logic fmtU;
    logic fmtJ;
    logic fmtS;
    logic fmtB;

    assign fmtU = extFmt == `EXT_U;
    assign fmtJ = extFmt == `EXT_J;
    assign fmtS = extFmt == `EXT_S;
    assign fmtB = extFmt == `EXT_B;

    // sign bit is always instruction bit 31
    assign imm[31]    = instrBits[31];
    assign imm[30:20] = fmtU ? instrBits[30:20] : {11{instrBits[31]}};
    assign imm[19:12] = (fmtU || fmtJ) ? instrBits[19:12] : {8{instrBits[31]}};
    assign imm[11]    = fmtU ? 1'b0 :
                        fmtB ? instrBits[7] :
                        fmtJ ? instrBits[20] : instrBits[31];
    assign imm[10:5]  = fmtU ? 6'b000000 : instrBits[30:25];
    assign imm[4:1]   = fmtU ? 4'b0000 :
                        (fmtS || fmtB) ? instrBits[11:8] : instrBits[24:21];
    assign imm[0]     = (fmtU || fmtJ || fmtB) ? 1'b0 :
                        fmtS ? instrBits[7] : instrBits[20];

endmodule

//--- rtl/idStage.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module idStage (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  block,
    input  logic                  validIn,
    input  decode_pkg::instrWord  instr,
    input  decode_pkg::xlenWord   pc,
    input  logic                  instrError,
    input  logic                  csrError,
    output logic                  validOut,
    output decode_pkg::xlenWord   pcOut,
    output decode_pkg::regIdx     rs1,
    output decode_pkg::regIdx     rs2,
    output decode_pkg::regIdx     rd,
    output decode_pkg::immWord    imm,
    output logic                  aluASrc,
    output decode_pkg::aluBSel    aluBSrc,
    output decode_pkg::aluCode    aluCtrl,
    output logic                  isMul,
    output logic                  isDiv,
    output decode_pkg::branchKind branch,
    output logic                  memRd,
    output logic                  memWr,
    output decode_pkg::memOpCode  memOp,
    output logic                  regWr,
    output logic                  csrOp,
    output decode_pkg::csrIdx     csrAddr,
    output logic                  ecall,
    output logic                  ebreak,
    output logic                  mret,
    output logic                  illegal
);
    import decode_pkg::*;

    logic     validQ;
    instrWord instrQ;
    xlenWord  pcQ;
    logic     instrErrQ;  // fetch fault travels with the word
    extFormat extFmt;
    logic     formatError;
    logic     sysUnknown; // funct3 0 system word that is not ecall/ebreak/mret

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else if (!block) begin
            validQ <= validIn;
        end
    end

    always_ff @(posedge clk) begin
        if (!block) begin
            instrQ    <= instr;
            pcQ       <= pc;
            instrErrQ <= instrError;
        end
    end

    opDecoder decoder (
        .opcode      (instrQ[6:0]),
        .funct3      (instrQ[14:12]),
        .funct7      (instrQ[31:25]),
        .extFmt      (extFmt),
        .aluASrc     (aluASrc),
        .aluBSrc     (aluBSrc),
        .aluCtrl     (aluCtrl),
        .isMul       (isMul),
        .isDiv       (isDiv),
        .branch      (branch),
        .memRd       (memRd),
        .memWr       (memWr),
        .regWr       (regWr),
        .csrOp       (csrOp),
        .formatError (formatError)
    );

    immGen immediate (
        .instrBits (instrQ[31:7]),
        .extFmt    (extFmt),
        .imm       (imm)
    );

    assign validOut = validQ;
    assign pcOut    = pcQ;
    assign rs1      = instrQ[19:15];
    assign rs2      = instrQ[24:20];
    assign rd       = instrQ[11:7];
    assign memOp    = instrQ[14:12];
    assign csrAddr  = instrQ[31:20];

    assign ecall  = instrQ == `INSTR_ECALL;
    assign ebreak = instrQ == `INSTR_EBREAK;
    assign mret   = instrQ == `INSTR_MRET;

    assign sysUnknown = instrQ[6:2] == `OPC_SYSTEM && instrQ[14:12] == 3'b000 &&
                        !(ecall || ebreak || mret);

    // csrError answers for the word now in decode
    assign illegal = formatError || instrErrQ || sysUnknown || (csrOp && csrError);

endmodule

//--- test/idStage_sva.sv
`timescale 1ns/1ps

module idStage_sva (
    input logic                clk,
    input logic                rstN,
    input logic                block,
    input logic                validOut,
    input decode_pkg::xlenWord pcOut,
    input logic                illegal,
    input logic                isMul,
    input logic                isDiv,
    input logic                aluASrc,
    input decode_pkg::aluBSel  aluBSrc,
    input logic                regWr,
    input logic                csrOp,
    input logic                ecall,
    input logic                ebreak,
    input logic                mret
);

    resetClearsValid: assert property (@(posedge clk) !rstN |=> !validOut)
        else $error("validOut high in the cycle after reset");

    // stage holds while downstream is busy
    blockHolds: assert property (@(posedge clk) disable iff (!rstN)
        block |=> $stable(validOut) && $stable(pcOut) && $stable(illegal))
        else $error("outputs changed while block was high");

    // mul/div is a register-register op with a write back
    mulDivExclusive: assert property (@(posedge clk)
        (isMul || isDiv) |-> isMul != isDiv && regWr && !aluASrc && aluBSrc == 2'd0)
        else $error("isMul and isDiv both high or not decoded as a register op");

    systemOneHot: assert property (@(posedge clk)
        (ecall || ebreak || mret) |-> $onehot({ecall, ebreak, mret}) && !csrOp && !regWr)
        else $error("ecall, ebreak, mret not one-hot or decoded as a CSR op");

endmodule

//--- test/idChecker.sv
`timescale 1ns/1ps

module idChecker (
    input  logic                  clk,
    input  logic                  armed,
    input  logic [127:0]          expName,
    input  decode_pkg::instrWord  expInstr,
    input  decode_pkg::xlenWord   expPc,
    input  decode_pkg::immWord    expImm,
    input  decode_pkg::aluCode    expAlu,
    input  decode_pkg::branchKind expBranch,
    input  logic [12:0]           expCtrl,
    input  logic                  expIllegal,
    input  logic                  validOut,
    input  decode_pkg::xlenWord   pcOut,
    input  decode_pkg::regIdx     rs1,
    input  decode_pkg::regIdx     rs2,
    input  decode_pkg::regIdx     rd,
    input  decode_pkg::immWord    imm,
    input  logic                  aluASrc,
    input  decode_pkg::aluBSel    aluBSrc,
    input  decode_pkg::aluCode    aluCtrl,
    input  logic                  isMul,
    input  logic                  isDiv,
    input  decode_pkg::branchKind branch,
    input  logic                  memRd,
    input  logic                  memWr,
    input  decode_pkg::memOpCode  memOp,
    input  logic                  regWr,
    input  logic                  csrOp,
    input  decode_pkg::csrIdx     csrAddr,
    input  logic                  ecall,
    input  logic                  ebreak,
    input  logic                  mret,
    input  logic                  illegal,
    output int                    checkedCount,
    output int                    errorCount
);
    import decode_pkg::*;

    logic         dueArmed = 1'b0; // row whose word is now in decode
    logic [127:0] dueName;
    instrWord     dueInstr;
    xlenWord      duePc;
    immWord       dueImm;
    aluCode       dueAlu;
    branchKind    dueBranch;
    logic [12:0]  dueCtrl;
    logic         dueIllegal;
    logic [12:0]  ctrlBits;
    logic [146:0] want;
    logic [146:0] got;
    int           checked = 0;
    int           errors = 0;

    assign ctrlBits = {validOut, aluASrc, aluBSrc, isMul, isDiv, memRd, memWr, regWr, csrOp,
                       ecall, ebreak, mret};
    assign checkedCount = checked;
    assign errorCount   = errors;

    always @(posedge clk) begin
        dueArmed   <= armed;
        dueName    <= expName;
        dueInstr   <= expInstr;
        duePc      <= expPc;
        dueImm     <= expImm;
        dueAlu     <= expAlu;
        dueBranch  <= expBranch;
        dueCtrl    <= expCtrl;
        dueIllegal <= expIllegal;
    end

    // compare mid-cycle, away from both edges
    always @(negedge clk) begin
        if (dueArmed) begin
            if (!dueCtrl[12]) begin
                want = {146'd0, 1'b0};
                got  = {146'd0, validOut};
            end else if (dueIllegal) begin
                want = {145'd0, 1'b1, 1'b1};
                got  = {145'd0, validOut, illegal};
            end else begin
                // rs1 19:15, rs2 24:20, rd 11:7, funct3 14:12, csr 31:20
                want = {duePc, dueInstr[19:15], dueInstr[24:20], dueInstr[11:7],
                        dueInstr[14:12], dueInstr[31:20], dueImm, dueAlu, dueBranch,
                        dueCtrl, 1'b0};
                got  = {pcOut, rs1, rs2, rd, memOp, csrAddr, imm, aluCtrl, branch,
                        ctrlBits, illegal};
            end
            checked++;
            if (want !== got) begin
                errors++;
                $display("mismatch %0s expected %h actual %h", dueName, want, got);
            end else begin
                $display("pass %0s", dueName);
            end
        end
    end

endmodule

//--- test/idStageTb.sv
`timescale 1ns/1ps

module idStageTb;
    import decode_pkg::*;

    localparam int maxRows     = 64;
    localparam int resetCycles = 16;

    logic      clk;
    logic      rstN;
    logic      block;
    logic      validIn;
    instrWord  instr;
    xlenWord   pc;
    logic      instrError;
    logic      csrError;

    logic      validOut;
    xlenWord   pcOut;
    regIdx     rs1;
    regIdx     rs2;
    regIdx     rd;
    immWord    imm;
    logic      aluASrc;
    aluBSel    aluBSrc;
    aluCode    aluCtrl;
    logic      isMul;
    logic      isDiv;
    branchKind branch;
    logic      memRd;
    logic      memWr;
    memOpCode  memOp;
    logic      regWr;
    logic      csrOp;
    csrIdx     csrAddr;
    logic      ecall;
    logic      ebreak;
    logic      mret;
    logic      illegal;

    // golden rows
    logic [127:0] rowName [maxRows];
    logic         rowBlock [maxRows];
    logic         rowValid [maxRows];
    instrWord     rowInstr [maxRows];
    xlenWord      rowPc [maxRows];
    logic         rowIe [maxRows];
    logic         rowCe [maxRows];
    immWord       rowImm [maxRows];
    aluCode       rowAlu [maxRows];
    branchKind    rowBranch [maxRows];
    logic [12:0]  rowCtrl [maxRows];
    logic         rowIllegal [maxRows];
    int           rowCount;

    logic         armed;
    logic [127:0] expName;
    instrWord     expInstr;
    xlenWord      expPc;
    immWord       expImm;
    aluCode       expAlu;
    branchKind    expBranch;
    logic [12:0]  expCtrl;
    logic         expIllegal;
    instrWord     heldInstr; // word now sitting in decode
    xlenWord      heldPc;
    int           checkedCount;
    int           errorCount;

    idStage UUT (
        .clk(clk), .rstN(rstN), .block(block), .validIn(validIn),
        .instr(instr), .pc(pc), .instrError(instrError), .csrError(csrError),
        .validOut(validOut), .pcOut(pcOut), .rs1(rs1), .rs2(rs2), .rd(rd),
        .imm(imm), .aluASrc(aluASrc), .aluBSrc(aluBSrc), .aluCtrl(aluCtrl),
        .isMul(isMul), .isDiv(isDiv), .branch(branch), .memRd(memRd),
        .memWr(memWr), .memOp(memOp), .regWr(regWr), .csrOp(csrOp),
        .csrAddr(csrAddr), .ecall(ecall), .ebreak(ebreak), .mret(mret),
        .illegal(illegal)
    );

    idChecker monitor (
        .clk(clk), .armed(armed), .expName(expName), .expInstr(expInstr),
        .expPc(expPc), .expImm(expImm), .expAlu(expAlu), .expBranch(expBranch),
        .expCtrl(expCtrl), .expIllegal(expIllegal),
        .validOut(validOut), .pcOut(pcOut), .rs1(rs1), .rs2(rs2), .rd(rd),
        .imm(imm), .aluASrc(aluASrc), .aluBSrc(aluBSrc), .aluCtrl(aluCtrl),
        .isMul(isMul), .isDiv(isDiv), .branch(branch), .memRd(memRd),
        .memWr(memWr), .memOp(memOp), .regWr(regWr), .csrOp(csrOp),
        .csrAddr(csrAddr), .ecall(ecall), .ebreak(ebreak), .mret(mret),
        .illegal(illegal), .checkedCount(checkedCount), .errorCount(errorCount)
    );

    bind idStage idStage_sva assertions (
        .clk(clk), .rstN(rstN), .block(block), .validOut(validOut),
        .pcOut(pcOut), .illegal(illegal), .isMul(isMul), .isDiv(isDiv),
        .aluASrc(aluASrc), .aluBSrc(aluBSrc), .regWr(regWr), .csrOp(csrOp),
        .ecall(ecall), .ebreak(ebreak), .mret(mret)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic loadGolden();
        int             fd;
        int             got;
        logic [1023:0]  skipLine;
        logic [127:0]   tName;
        logic           tBlock;
        logic           tValid;
        instrWord       tInstr;
        xlenWord        tPc;
        logic           tIe;
        logic           tCe;
        immWord         tImm;
        aluCode         tAlu;
        branchKind      tBranch;
        logic [12:0]    tCtrl;
        logic           tIllegal;
        rowCount = 0;
        fd = $fopen("test/decode_golden.txt", "r");
        if (fd != 0) begin
            got = $fgets(skipLine, fd); // two column lines
            got = $fgets(skipLine, fd);
            while (!$feof(fd) && rowCount < maxRows) begin
                got = $fscanf(fd, "%s %h %h %h %h %h %h %h %h %h %h %h\n", tName, tBlock,
                              tValid, tInstr, tPc, tIe, tCe, tImm, tAlu, tBranch, tCtrl,
                              tIllegal);
                if (got != 12) break;
                rowName[rowCount]    = tName;
                rowBlock[rowCount]   = tBlock;
                rowValid[rowCount]   = tValid;
                rowInstr[rowCount]   = tInstr;
                rowPc[rowCount]      = tPc;
                rowIe[rowCount]      = tIe;
                rowCe[rowCount]      = tCe;
                rowImm[rowCount]     = tImm;
                rowAlu[rowCount]     = tAlu;
                rowBranch[rowCount]  = tBranch;
                rowCtrl[rowCount]    = tCtrl;
                rowIllegal[rowCount] = tIllegal;
                rowCount++;
            end
            $fclose(fd);
        end
    endtask

    task automatic runRows();
        logic prevCe;
        prevCe = 1'b0;
        for (int i = 0; i < rowCount; i++) begin
            @(posedge clk);
            #1;
            block      = rowBlock[i];
            validIn    = rowValid[i];
            instrError = rowIe[i];
            if (rowValid[i]) begin
                instr = rowInstr[i];
                pc    = rowPc[i];
            end else begin
                instr = $urandom;
                pc    = {$urandom, $urandom};
            end
            if (!rowBlock[i]) begin
                heldInstr = instr;
                heldPc    = pc;
            end
            csrError   = prevCe; // CSR file answers for the word in decode
            if (!rowBlock[i]) begin
                prevCe = rowCe[i];
            end
            armed      = 1'b1;
            expName    = rowName[i];
            expInstr   = heldInstr;
            expPc      = heldPc;
            expImm     = rowImm[i];
            expAlu     = rowAlu[i];
            expBranch  = rowBranch[i];
            expCtrl    = rowCtrl[i];
            expIllegal = rowIllegal[i];
        end
        @(posedge clk);
        #1;
        block    = 1'b0;
        validIn  = 1'b0;
        armed    = 1'b0;
        csrError = prevCe;
    endtask

    // watchdog sized from the row count
    initial begin
        #1;
        #((rowCount + resetCycles + 20) * 4);
        $display("run timed out before all golden rows were checked");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h335e_21c1));
        rstN       = 1'b0;
        block      = 1'b0;
        validIn    = 1'b0;
        instr      = '0;
        pc         = '0;
        instrError = 1'b0;
        csrError   = 1'b0;
        armed      = 1'b0;
        expName    = '0;
        expInstr   = '0;
        expPc      = '0;
        expImm     = '0;
        expAlu     = '0;
        expBranch  = '0;
        expCtrl    = '0;
        expIllegal = 1'b0;
        heldInstr  = '0;
        heldPc     = '0;
        loadGolden();
        if (rowCount == 0) begin
            $display("no rows could be read from test/decode_golden.txt");
            $display("Testbench failed");
        end else begin
            repeat (resetCycles) @(posedge clk);
            #1 rstN = 1'b1;
            runRows();
            wait (checkedCount == rowCount);
            $display("%0d tests, %0d passed, %0d failed", checkedCount,
                     checkedCount - errorCount, errorCount);
            if (errorCount == 0) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
        end
        $finish;
    end

endmodule

//--- test/decode_golden.txt
# name block validIn instr pc instrError csrError | expected imm aluCtrl branch ctrl illegal
# ctrl = {validOut aluASrc aluBSrc[1:0] isMul isDiv memRd memWr regWr csrOp ecall ebreak mret}
bubbleStart 0 0 00000000 0 0 0 00000000 0 0 0000 0
lui 0 1 123452B7 80000000 0 0 12345000 f 0 1410 0
auipc 0 1 FFFFF317 80000004 0 0 FFFFF000 0 0 1c10 0
jalFwd 0 1 001000EF 80000008 0 0 00000800 0 1 1a10 0
jalBack 0 1 FFDFF06F 8000000c 0 0 fffffffc 0 1 1a10 0
jalr 0 1 008100E7 80000010 0 0 00000008 0 2 1a10 0
jalrBadF3 0 1 008110E7 80000014 0 0 00000000 0 0 1000 1
beq 0 1 00208863 80000018 0 0 00000010 2 4 1000 0
blt 0 1 0020C863 8000001c 0 0 00000010 2 6 1000 0
bgeu 0 1 0020F863 80000020 0 0 00000010 3 7 1000 0
bltuBack 0 1 FE20ECE3 80000024 0 0 fffffff8 3 6 1000 0
branchBadF3 0 1 0020A863 80000028 0 0 00000000 0 0 1000 1
ld 0 1 FF023183 8000002c 0 0 fffffff0 0 0 1450 0
lwu 0 1 00426183 80000030 0 0 00000004 0 0 1450 0
loadBadF3 0 1 00427183 80000034 0 0 00000000 0 0 1000 1
sd 0 1 00533C23 80000038 0 0 00000018 0 0 1420 0
storeBadF3 0 1 00534C23 8000003c 0 0 00000000 0 0 1000 1
addi 0 1 FFF10093 80000040 0 0 ffffffff 0 0 1410 0
srai 0 1 43F15093 80000044 0 0 0000043f d 0 1410 0
slliBadF7 0 1 40011093 80000048 0 0 00000000 0 0 1000 1
addiw 0 1 0051009B 8000004c 0 0 00000005 0 0 1410 0
slliwBadF7 0 1 0201109B 80000050 0 0 00000000 0 0 1000 1
sub 0 1 402081B3 80000054 0 0 00000402 8 0 1010 0
mul 0 1 022081B3 80000058 0 0 00000022 0 0 1110 0
divu 0 1 0220D1B3 8000005c 0 0 00000022 5 0 1090 0
opBadF7 0 1 402091B3 80000060 0 0 00000000 0 0 1000 1
mulw 0 1 022081BB 80000064 0 0 00000022 0 0 1110 0
op32BadF3 0 1 0020A1BB 80000068 0 0 00000000 0 0 1000 1
ecall 0 1 00000073 8000006c 0 0 00000000 f 0 1604 0
ebreak 0 1 00100073 80000070 0 0 00000001 f 0 1602 0
mret 0 1 30200073 80000074 0 0 00000302 f 0 1601 0
wfi 0 1 10500073 80000078 0 0 00000000 0 0 1000 1
csrrw 0 1 300110F3 8000007c 0 0 00000300 f 0 1618 0
csrrsCsrErr 0 1 300120F3 80000080 0 1 00000000 0 0 1000 1
fetchFault 0 1 FFF10093 80000084 1 0 00000000 0 0 1000 1
lowBits10 0 1 FFF10092 80000088 0 0 00000000 0 0 1000 1
unknownOpc 0 1 0000007F 8000008c 0 0 00000000 0 0 1000 1
holdLoad 0 1 123452B7 80000090 0 0 12345000 f 0 1410 0
holdBlock1 1 1 00000073 80000094 0 0 12345000 f 0 1410 0
holdBlock2 1 0 00000000 0 0 0 12345000 f 0 1410 0
holdRelease 0 1 00000073 80000098 0 0 00000000 f 0 1604 0
bubbleEnd 0 0 00000000 0 0 0 00000000 0 0 0000 0

//--- files.f
+incdir+rtl
rtl/decode_pkg.sv
rtl/opDecoder.sv
rtl/immGen.sv
rtl/idStage.sv
test/idStage_sva.sv
test/idChecker.sv
test/idStageTb.sv

//--- Makefile
TOP := idStageTb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the decode stage testbench"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f files.f -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir
